// ==== hw/bpu_pkg.sv ====
package bpu_pkg;

    ////////////////////////////////////////////////////////////
    // branch classes, as resolved by execute
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        // not a branch, never trained
        BR_NONE = 2'b00,
        // conditional, direction from the pht
        BR_COND = 2'b01,
        // unconditional direct
        BR_JUMP = 2'b10,
        // call, predicted like a jump
        BR_CALL = 2'b11
    } br_type_e;

    ////////////////////////////////////////////////////////////
    // two-bit saturating counter
    ////////////////////////////////////////////////////////////

    // 00 strong nt, 01 weak nt, 10 weak t, 11 strong t
    typedef logic [1:0] counter_t;

    // every counter starts weak not-taken
    localparam counter_t CTR_RESET = 2'b01;

    // default sizes, overridden from the top level
    // word address, byte offset already dropped
    localparam int DEF_PC_W      = 30;
    localparam int DEF_PHT_IDX_W = 10;
    localparam int DEF_BTB_IDX_W = 6;
    localparam int DEF_UPD_DEPTH = 4;

endpackage

// ==== hw/pred_table.sv ====
module pred_table #(
    parameter type entry_t   = logic [1:0],
    parameter int  IDX_W     = 4,
    parameter entry_t RESET_VAL = '0
) (
    input  logic             clk,
    input  logic             arst_n,

    // read port a
    input  logic [IDX_W-1:0] rd_addr_a,
    output entry_t           rd_data_a,

    // read port b
    input  logic [IDX_W-1:0] rd_addr_b,
    output entry_t           rd_data_b,

    // single write port
    input  logic             wr_en,
    input  logic [IDX_W-1:0] wr_addr,
    input  entry_t           wr_data
);

    localparam int DEPTH = 2 ** IDX_W;

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    // plain flop array, no sram
    entry_t mem [DEPTH];

    // every entry back to the reset value
    // write lands at the edge ending the cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= RESET_VAL;
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // asynchronous reads
    ////////////////////////////////////////////////////////////

    // old value seen in the write cycle, new one from the next
    assign rd_data_a = mem[rd_addr_a];
    assign rd_data_b = mem[rd_addr_b];

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // an x address would corrupt an unknown entry
    a_wr_addr_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        wr_en |-> !$isunknown(wr_addr)
    ) else $error("pred_table: write with unknown address");

endmodule

// ==== hw/pht.sv ====
module pht #(
    parameter int PC_W      = bpu_pkg::DEF_PC_W,
    parameter int PHT_IDX_W = bpu_pkg::DEF_PHT_IDX_W
) (
    input  logic                clk,
    input  logic                arst_n,

    // prediction side
    input  logic [PC_W-1:0]     pc,
    output logic                pred_ctr_taken,

    // training side, from the update queue
    input  logic                trn_valid,
    input  logic [PC_W-1:0]     trn_pc,
    input  bpu_pkg::br_type_e   trn_type,
    input  logic                trn_taken
);

    // counter read for prediction
    bpu_pkg::counter_t ctr_pred;
    // counter read at the training pc
    bpu_pkg::counter_t ctr_old;
    // counter after one step
    bpu_pkg::counter_t ctr_new;
    logic              ctr_wr_en;

    ////////////////////////////////////////////////////////////
    // counter table
    ////////////////////////////////////////////////////////////

    // index is pc[PHT_IDX_W:1], same bits on both sides
    pred_table #(
        .entry_t   (bpu_pkg::counter_t),
        .IDX_W     (PHT_IDX_W),
        .RESET_VAL (bpu_pkg::CTR_RESET)
    ) table_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_addr_a (pc[PHT_IDX_W:1]),
        .rd_data_a (ctr_pred),
        .rd_addr_b (trn_pc[PHT_IDX_W:1]),
        .rd_data_b (ctr_old),
        .wr_en     (ctr_wr_en),
        .wr_addr   (trn_pc[PHT_IDX_W:1]),
        .wr_data   (ctr_new)
    );

    // upper bit set means weak or strong taken
    assign pred_ctr_taken = ctr_pred[1];

    ////////////////////////////////////////////////////////////
    // training
    ////////////////////////////////////////////////////////////

    // one step toward the resolved direction
    // held at 11 and at 00
    always_comb begin
        ctr_new = ctr_old;
        if (trn_taken && ctr_old != 2'b11) begin
            ctr_new = ctr_old + 2'b01;
        end else if (!trn_taken && ctr_old != 2'b00) begin
            ctr_new = ctr_old - 2'b01;
        end
    end

    // non-branches leave the counter alone
    assign ctr_wr_en = trn_valid && (trn_type != bpu_pkg::BR_NONE);

endmodule

// ==== hw/btb.sv ====
module btb #(
    parameter int PC_W      = bpu_pkg::DEF_PC_W,
    parameter int BTB_IDX_W = bpu_pkg::DEF_BTB_IDX_W
) (
    input  logic                clk,
    input  logic                arst_n,

    // lookup side
    input  logic [PC_W-1:0]     pc,
    output logic                btb_hit,
    output bpu_pkg::br_type_e   btb_type,
    output logic [PC_W-1:0]     btb_target,

    // training side, from the update queue
    input  logic                trn_valid,
    input  logic [PC_W-1:0]     trn_pc,
    input  bpu_pkg::br_type_e   trn_type,
    input  logic                trn_taken,
    input  logic [PC_W-1:0]     trn_target
);

    // tag is whatever the index leaves over
    localparam int TAG_W = PC_W - BTB_IDX_W;

    typedef struct packed {
        logic                valid;
        logic [TAG_W-1:0]    tag;
        logic [PC_W-1:0]     target;
        bpu_pkg::br_type_e   br_type;
    } btb_entry_t;

    btb_entry_t rd_entry;
    btb_entry_t wr_entry;
    logic       wr_en;

    ////////////////////////////////////////////////////////////
    // entry storage, direct mapped
    ////////////////////////////////////////////////////////////

    // all-zero reset clears every valid bit
    // port b unused, one lookup per cycle is enough
    pred_table #(
        .entry_t   (btb_entry_t),
        .IDX_W     (BTB_IDX_W),
        .RESET_VAL (btb_entry_t'('0))
    ) table_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_addr_a (pc[BTB_IDX_W-1:0]),
        .rd_data_a (rd_entry),
        .rd_addr_b ('0),
        .rd_data_b (),
        .wr_en     (wr_en),
        .wr_addr   (trn_pc[BTB_IDX_W-1:0]),
        .wr_data   (wr_entry)
    );

    ////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////

    // valid and full tag compare
    assign btb_hit    = rd_entry.valid && (rd_entry.tag == pc[PC_W-1:BTB_IDX_W]);
    assign btb_type   = rd_entry.br_type;
    assign btb_target = rd_entry.target;

    ////////////////////////////////////////////////////////////
    // training
    ////////////////////////////////////////////////////////////

    // taken branches only, not-taken ones keep the old target
    // an alias with another tag simply evicts
    assign wr_en = trn_valid && trn_taken && (trn_type != bpu_pkg::BR_NONE);

    always_comb begin
        wr_entry.valid   = 1'b1;
        wr_entry.tag     = trn_pc[PC_W-1:BTB_IDX_W];
        wr_entry.target  = trn_target;
        wr_entry.br_type = trn_type;
    end

endmodule

// ==== hw/update_queue.sv ====
module update_queue #(
    parameter int PC_W      = bpu_pkg::DEF_PC_W,
    parameter int UPD_DEPTH = bpu_pkg::DEF_UPD_DEPTH
) (
    input  logic                clk,
    input  logic                arst_n,

    // updates from execute, one credit each
    input  logic                upd_valid,
    input  logic [PC_W-1:0]     upd_pc,
    input  bpu_pkg::br_type_e   upd_type,
    input  logic                upd_taken,
    input  logic [PC_W-1:0]     upd_target,
    output logic                upd_credit,

    // head entry toward the tables
    output logic                trn_valid,
    output logic [PC_W-1:0]     trn_pc,
    output bpu_pkg::br_type_e   trn_type,
    output logic                trn_taken,
    output logic [PC_W-1:0]     trn_target
);

    localparam int PTR_W = (UPD_DEPTH > 1) ? $clog2(UPD_DEPTH) : 1;
    localparam int CNT_W = $clog2(UPD_DEPTH + 1);

    // payload arrays, one per field
    logic [PC_W-1:0]   q_pc     [UPD_DEPTH];
    bpu_pkg::br_type_e q_type   [UPD_DEPTH];
    logic              q_taken  [UPD_DEPTH];
    logic [PC_W-1:0]   q_target [UPD_DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;

    ////////////////////////////////////////////////////////////
    // drain side
    ////////////////////////////////////////////////////////////

    // tables never stall, so the head leaves every cycle
    assign trn_valid  = (count != '0);
    assign upd_credit = trn_valid;
    assign trn_pc     = q_pc[rd_ptr];
    assign trn_type   = q_type[rd_ptr];
    assign trn_taken  = q_taken[rd_ptr];
    assign trn_target = q_target[rd_ptr];

    // payload lands at the tail
    always_ff @(posedge clk) begin
        if (upd_valid) begin
            q_pc[wr_ptr]     <= upd_pc;
            q_type[wr_ptr]   <= upd_type;
            q_taken[wr_ptr]  <= upd_taken;
            q_target[wr_ptr] <= upd_target;
        end
    end

    // pointers wrap at depth, count tracks push minus pop
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (upd_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(UPD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (trn_valid) begin
                rd_ptr <= (rd_ptr == PTR_W'(UPD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(upd_valid) - CNT_W'(trn_valid);
        end
    end

    // sender out of credits must hold off
    a_no_write_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        upd_valid |-> (count != CNT_W'(UPD_DEPTH))
    ) else $error("update_queue: write while full");

    // pointers must agree that an entry is there
    a_no_credit_empty: assert property (
        @(posedge clk) disable iff (!arst_n)
        upd_credit |-> (rd_ptr != wr_ptr) || (count == CNT_W'(UPD_DEPTH))
    ) else $error("update_queue: credit returned while empty");

endmodule

// ==== hw/bpu.sv ====
module bpu #(
    parameter int PC_W      = bpu_pkg::DEF_PC_W,
    parameter int PHT_IDX_W = bpu_pkg::DEF_PHT_IDX_W,
    parameter int BTB_IDX_W = bpu_pkg::DEF_BTB_IDX_W,
    parameter int UPD_DEPTH = bpu_pkg::DEF_UPD_DEPTH
) (
    input  logic                clk,
    input  logic                arst_n,

    // fetch lookup, answered in the same cycle
    input  logic [PC_W-1:0]     pc,
    output logic                pred_hit,
    output logic                pred_taken,
    output logic [PC_W-1:0]     pred_target,

    // training from execute
    input  logic                upd_valid,
    input  logic [PC_W-1:0]     upd_pc,
    input  bpu_pkg::br_type_e   upd_type,
    input  logic                upd_taken,
    input  logic [PC_W-1:0]     upd_target,
    output logic                upd_credit
);

    // queue head, shared by both tables
    logic              trn_valid;
    logic [PC_W-1:0]   trn_pc;
    bpu_pkg::br_type_e trn_type;
    logic              trn_taken;
    logic [PC_W-1:0]   trn_target;

    logic              pred_ctr_taken;
    logic              btb_hit;
    bpu_pkg::br_type_e btb_type;
    logic [PC_W-1:0]   btb_target;

    ////////////////////////////////////////////////////////////
    // training path
    ////////////////////////////////////////////////////////////

    update_queue #(
        .PC_W      (PC_W),
        .UPD_DEPTH (UPD_DEPTH)
    ) queue_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .upd_valid  (upd_valid),
        .upd_pc     (upd_pc),
        .upd_type   (upd_type),
        .upd_taken  (upd_taken),
        .upd_target (upd_target),
        .upd_credit (upd_credit),
        .trn_valid  (trn_valid),
        .trn_pc     (trn_pc),
        .trn_type   (trn_type),
        .trn_taken  (trn_taken),
        .trn_target (trn_target)
    );

    pht #(
        .PC_W      (PC_W),
        .PHT_IDX_W (PHT_IDX_W)
    ) pht_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .pc             (pc),
        .pred_ctr_taken (pred_ctr_taken),
        .trn_valid      (trn_valid),
        .trn_pc         (trn_pc),
        .trn_type       (trn_type),
        .trn_taken      (trn_taken)
    );

    btb #(
        .PC_W      (PC_W),
        .BTB_IDX_W (BTB_IDX_W)
    ) btb_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .pc         (pc),
        .btb_hit    (btb_hit),
        .btb_type   (btb_type),
        .btb_target (btb_target),
        .trn_valid  (trn_valid),
        .trn_pc     (trn_pc),
        .trn_type   (trn_type),
        .trn_taken  (trn_taken),
        .trn_target (trn_target)
    );

    ////////////////////////////////////////////////////////////
    // prediction
    ////////////////////////////////////////////////////////////

    // no btb hit means no target, so never taken
    assign pred_hit    = btb_hit;
    assign pred_target = btb_target;

    // jumps and calls always go, conditionals ask the counter
    assign pred_taken = btb_hit &&
                        ((btb_type == bpu_pkg::BR_JUMP) ||
                         (btb_type == bpu_pkg::BR_CALL) ||
                         ((btb_type == bpu_pkg::BR_COND) && pred_ctr_taken));

endmodule

// ==== tb/bpu_ref_model.svh ====
`ifndef BPU_REF_MODEL_SVH
`define BPU_REF_MODEL_SVH

// direction counters, one per pht index
bpu_pkg::counter_t         ref_ctr    [2 ** PHT_IDX_W];

// btb fields, one array per field
logic                      ref_valid  [2 ** BTB_IDX_W];
logic [PC_W-BTB_IDX_W-1:0] ref_tag    [2 ** BTB_IDX_W];
logic [PC_W-1:0]           ref_target [2 ** BTB_IDX_W];
bpu_pkg::br_type_e         ref_type   [2 ** BTB_IDX_W];

// counters weak not-taken, btb empty
function automatic void model_reset();
    foreach (ref_ctr[i]) begin
        ref_ctr[i] = 2'b01;
    end
    foreach (ref_valid[i]) begin
        ref_valid[i]  = 1'b0;
        ref_tag[i]    = '0;
        ref_target[i] = '0;
        ref_type[i]   = bpu_pkg::BR_NONE;
    end
endfunction

// applied when the update is sent, the dut catches up later
function automatic void model_train(input logic [PC_W-1:0] upc,
                                    input bpu_pkg::br_type_e utype,
                                    input logic utaken,
                                    input logic [PC_W-1:0] utarget);
    int pidx;
    int bidx;
    pidx = int'(upc[PHT_IDX_W:1]);
    bidx = int'(upc[BTB_IDX_W-1:0]);
    if (utype == bpu_pkg::BR_NONE) begin
        return;
    end
    // saturate at 3 going up, at 0 going down
    if (utaken) begin
        if (ref_ctr[pidx] < 2'd3) begin
            ref_ctr[pidx] = ref_ctr[pidx] + 2'd1;
        end
    end else if (ref_ctr[pidx] > 2'd0) begin
        ref_ctr[pidx] = ref_ctr[pidx] - 2'd1;
    end
    // only taken branches leave a target behind
    if (utaken) begin
        ref_valid[bidx]  = 1'b1;
        ref_tag[bidx]    = upc[PC_W-1:BTB_IDX_W];
        ref_target[bidx] = utarget;
        ref_type[bidx]   = utype;
    end
endfunction

function automatic void model_predict(input logic [PC_W-1:0] ppc,
                                      output logic hit,
                                      output logic taken,
                                      output logic [PC_W-1:0] target);
    int pidx;
    int bidx;
    pidx   = int'(ppc[PHT_IDX_W:1]);
    bidx   = int'(ppc[BTB_IDX_W-1:0]);
    hit    = ref_valid[bidx] && (ref_tag[bidx] == ppc[PC_W-1:BTB_IDX_W]);
    target = ref_target[bidx];
    taken  = 1'b0;
    if (hit) begin
        case (ref_type[bidx])
            bpu_pkg::BR_JUMP: taken = 1'b1;
            bpu_pkg::BR_CALL: taken = 1'b1;
            // weak or strong taken
            bpu_pkg::BR_COND: taken = (ref_ctr[pidx] >= 2'd2);
            default:          taken = 1'b0;
        endcase
    end
endfunction

`endif

// ==== tb/bpu_tb.sv ====
module bpu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PC_W       = bpu_pkg::DEF_PC_W;
    localparam int PHT_IDX_W  = bpu_pkg::DEF_PHT_IDX_W;
    localparam int BTB_IDX_W  = bpu_pkg::DEF_BTB_IDX_W;
    localparam int UPD_DEPTH  = bpu_pkg::DEF_UPD_DEPTH;
    localparam int WAIT_LIMIT = 100;

    logic              clk;
    logic              arst_n;
    logic [PC_W-1:0]   pc;
    logic              pred_hit;
    logic              pred_taken;
    logic [PC_W-1:0]   pred_target;
    logic              upd_valid;
    logic [PC_W-1:0]   upd_pc;
    bpu_pkg::br_type_e upd_type;
    logic              upd_taken;
    logic [PC_W-1:0]   upd_target;
    logic              upd_credit;

    int                errors;
    int                credits;
    int                sent_cnt;
    int                ret_cnt;
    bit                hung;
    logic [15:0]       lfsr_state;
    logic [PC_W-1:0]   pool [8];

    `include "bpu_ref_model.svh"

    bpu bpu_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .pc          (pc),
        .pred_hit    (pred_hit),
        .pred_taken  (pred_taken),
        .pred_target (pred_target),
        .upd_valid   (upd_valid),
        .upd_pc      (upd_pc),
        .upd_type    (upd_type),
        .upd_taken   (upd_taken),
        .upd_target  (upd_target),
        .upd_credit  (upd_credit)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // random bits, galois lfsr x^16+x^14+x^13+x^11+1
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        end
        return val;
    endfunction

    ////////////////////////////////////////////////////////////
    // credit tracking
    ////////////////////////////////////////////////////////////

    // pulse sampled mid-cycle, well away from the edges
    always @(negedge clk) begin
        if (arst_n && upd_credit) begin
            if (credits >= UPD_DEPTH) begin
                $display("ERROR: credit returned with no update outstanding");
                errors++;
            end
            credits++;
            ret_cnt++;
        end
    end

    // a wait loop that ran out ends the run here
    initial begin
        wait (hung);
        $display("timeout, errors so far: %0d", errors);
        $display("Checks failed");
        $finish;
    end

    // one update, held back while no credit is left
    task automatic send_update(input logic [PC_W-1:0] p, input bpu_pkg::br_type_e t,
                               input logic tk, input logic [PC_W-1:0] tgt);
        int guard;
        guard = 0;
        @(posedge clk);
        while (credits == 0 && !hung) begin
            upd_valid <= 1'b0;
            @(posedge clk);
            guard++;
            if (guard > WAIT_LIMIT) begin
                $display("ERROR: no credit came back while waiting to send");
                hung = 1'b1;
            end
        end
        upd_valid  <= 1'b1;
        upd_pc     <= p;
        upd_type   <= t;
        upd_taken  <= tk;
        upd_target <= tgt;
        credits--;
        sent_cnt++;
        model_train(p, t, tk, tgt);
    endtask

    task automatic random_update();
        int                idx;
        bpu_pkg::br_type_e t;
        logic              tk;
        logic [PC_W-1:0]   tgt;
        idx = int'(take_bits(3));
        t   = bpu_pkg::br_type_e'(2'(take_bits(2)));
        tk  = take_bits(1) != 0;
        tgt = PC_W'(take_bits(PC_W));
        send_update(pool[idx], t, tk, tgt);
    endtask

    // all credits home, then two spare cycles
    task automatic drain_queue();
        int guard;
        guard = 0;
        @(posedge clk);
        upd_valid <= 1'b0;
        while (credits != UPD_DEPTH && !hung) begin
            @(posedge clk);
            guard++;
            if (guard > WAIT_LIMIT) begin
                $display("ERROR: credits did not return, %0d outstanding", UPD_DEPTH - credits);
                hung = 1'b1;
            end
        end
        repeat (2) @(posedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // prediction probe
    ////////////////////////////////////////////////////////////

    task automatic check_pc(input string name, input logic [PC_W-1:0] p);
        logic            exp_hit;
        logic            exp_taken;
        logic [PC_W-1:0] exp_target;
        @(posedge clk);
        pc <= p;
        @(negedge clk);
        model_predict(p, exp_hit, exp_taken, exp_target);
        if (pred_hit !== exp_hit) begin
            $display("FAILED %s pc %h hit: expected %b actual %b", name, p, exp_hit, pred_hit);
            errors++;
        end
        if (pred_taken !== exp_taken) begin
            $display("FAILED %s pc %h taken: expected %b actual %b",
                     name, p, exp_taken, pred_taken);
            errors++;
        end
        // target only means something on a hit
        if (exp_hit && pred_target !== exp_target) begin
            $display("FAILED %s pc %h target: expected %h actual %h",
                     name, p, exp_target, pred_target);
            errors++;
        end
    endtask

    task automatic check_pool(input string name);
        for (int i = 0; i < 8; i++) begin
            check_pc(name, pool[i]);
        end
    endtask

    task automatic train_and_check(input string name, input logic [PC_W-1:0] p,
                                   input bpu_pkg::br_type_e t, input logic tk,
                                   input logic [PC_W-1:0] tgt);
        send_update(p, t, tk, tgt);
        drain_queue();
        check_pc(name, p);
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [PC_W-1:0]   tgt;
        bpu_pkg::br_type_e t;
        arst_n     = 1'b0;
        pc         = '0;
        upd_valid  = 1'b0;
        upd_pc     = '0;
        upd_type   = bpu_pkg::BR_NONE;
        upd_taken  = 1'b0;
        upd_target = '0;
        errors     = 0;
        credits    = UPD_DEPTH;
        sent_cnt   = 0;
        ret_cnt    = 0;
        lfsr_state = 16'd81;
        // 0 and 1 share btb index 0x10 with different tags
        pool[0] = 30'h0000_0010;
        pool[1] = 30'h0001_0050;
        pool[2] = 30'h0000_0021;
        pool[3] = 30'h0000_0232;
        pool[4] = 30'h0002_0003;
        pool[5] = 30'h0000_0415;
        pool[6] = 30'h0003_0d2e;
        pool[7] = 30'h0000_0739;
        model_reset();
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
        end
        arst_n <= 1'b1;

        // nothing valid out of reset, monitor watches credits
        check_pool("reset");

        // saturate up, saturate down, then random with none mixed in
        tgt = PC_W'(take_bits(PC_W));
        for (int i = 0; i < 4; i++) begin
            train_and_check("counter", pool[2], bpu_pkg::BR_COND, 1'b1, tgt);
        end
        for (int i = 0; i < 4; i++) begin
            train_and_check("counter", pool[2], bpu_pkg::BR_COND, 1'b0, tgt);
        end
        for (int i = 0; i < 24; i++) begin
            t = take_bits(1) != 0 ? bpu_pkg::BR_COND : bpu_pkg::BR_NONE;
            train_and_check("counter", pool[2], t, take_bits(1) != 0, tgt);
        end

        // both counters driven to 00 first, jump and call must still go
        for (int i = 0; i < 3; i++) begin
            train_and_check("unconditional", pool[3], bpu_pkg::BR_COND, 1'b0, tgt);
            train_and_check("unconditional", pool[4], bpu_pkg::BR_COND, 1'b0, tgt);
        end
        train_and_check("unconditional", pool[3], bpu_pkg::BR_JUMP, 1'b1, PC_W'(take_bits(PC_W)));
        train_and_check("unconditional", pool[4], bpu_pkg::BR_CALL, 1'b1, PC_W'(take_bits(PC_W)));

        // second tag on the same index evicts the first
        train_and_check("alias", pool[0], bpu_pkg::BR_COND, 1'b1, PC_W'(take_bits(PC_W)));
        train_and_check("alias", pool[1], bpu_pkg::BR_JUMP, 1'b1, PC_W'(take_bits(PC_W)));
        check_pc("alias", pool[0]);
        train_and_check("alias", pool[0], bpu_pkg::BR_JUMP, 1'b1, PC_W'(take_bits(PC_W)));
        check_pc("alias", pool[1]);

        // burst, back to back as far as credits go
        for (int i = 0; i < 40; i++) begin
            random_update();
        end
        drain_queue();
        if (ret_cnt != sent_cnt) begin
            $display("FAILED credits returned: expected %0d actual %0d", sent_cnt, ret_cnt);
            errors++;
        end
        if (credits != UPD_DEPTH) begin
            $display("FAILED credits held: expected %0d actual %0d", UPD_DEPTH, credits);
            errors++;
        end
        check_pool("credits");

        // 300 updates, 30 batches of 10
        for (int b = 0; b < 30; b++) begin
            for (int i = 0; i < 10; i++) begin
                random_update();
            end
            drain_queue();
            check_pool("random");
        end

        $display("errors: %0d, updates sent: %0d, credits returned: %0d",
                 errors, sent_cnt, ret_cnt);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+tb
hw/bpu_pkg.sv
hw/pred_table.sv
hw/pht.sv
hw/btb.sv
hw/update_queue.sv
hw/bpu.sv
tb/bpu_tb.sv

// ==== Makefile ====
SIM := obj_dir/Vbpu_tb
SRCS := $(shell grep -v '^+' verilog.f) tb/bpu_ref_model.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): verilog.f $(SRCS)
	verilator --binary --timing --assert -f verilog.f --top-module bpu_tb -o Vbpu_tb

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir
